//--- lane_seq_pkg.sv
/*
 * Lane sequencer package
 * Lane count, field widths, unit codes and operand slot indices
 */
package lane_seq_pkg;

  //////////////////////////////
  // Lane geometry
  //////////////////////////////

  localparam int NrLanes = 4;
  localparam int LaneIdW = $clog2(NrLanes);

  //////////////////////////////
  // Instruction fields
  //////////////////////////////

  localparam int NrVInsn = 8;
  localparam int VidW    = $clog2(NrVInsn);
  localparam int VlW     = 16;
  localparam int RegW    = 5;

  // Mask operands are fetched one 64-bit word at a time per lane
  localparam int              ElenBits = 64;
  localparam logic [RegW-1:0] VmaskReg = 5'd0;

  // Functional unit codes
  localparam int              VfuW     = 2;
  localparam logic [VfuW-1:0] VfuAlu   = 2'd0;
  localparam logic [VfuW-1:0] VfuMfpu  = 2'd1;
  localparam logic [VfuW-1:0] VfuStore = 2'd2;

  //////////////////////////////
  // Operand request slots
  //////////////////////////////

  localparam int NrOpQueues = 6;
  localparam int OqAluA     = 0;
  localparam int OqAluB     = 1;
  localparam int OqMfpuA    = 2;
  localparam int OqMfpuB    = 3;
  localparam int OqStA      = 4;
  localparam int OqMaskM    = 5;

  // Bits of one request as held by the intake register
  localparam int ReqW = VidW + VfuW + 2 * VlW + 3 * RegW + 3;

endpackage

//--- lane_seq_if.sv
/*
 * Lane sequencer interfaces
 * Accepted request towards issue, and operand commands towards the slots
 */
`timescale 1ns/1ps

interface vinsn_req_if;
  import lane_seq_pkg::*;

  logic            valid;
  logic            ready;
  logic [VidW-1:0] id;
  logic [VfuW-1:0] vfu;
  logic [VlW-1:0]  vl;
  logic [VlW-1:0]  vstart;
  logic [RegW-1:0] vs1;
  logic [RegW-1:0] vs2;
  logic [RegW-1:0] vd;
  logic            vm;
  logic            use_vs1;
  logic            use_vs2;

  modport intake (
    output valid, id, vfu, vl, vstart, vs1, vs2, vd, vm, use_vs1, use_vs2,
    input  ready
  );

  modport issue (
    input  valid, id, vfu, vl, vstart, vs1, vs2, vd, vm, use_vs1, use_vs2,
    output ready
  );

endinterface

interface opreq_if;
  import lane_seq_pkg::*;

  // One-cycle load strobe per slot
  logic [NrOpQueues-1:0]           push;
  logic [NrOpQueues-1:0][VidW-1:0] id;
  logic [NrOpQueues-1:0][RegW-1:0] vs;
  logic [NrOpQueues-1:0][VlW-1:0]  vl;
  logic [NrOpQueues-1:0][VlW-1:0]  vstart;
  // Slot holds a command not yet taken
  logic [NrOpQueues-1:0]           busy;

  modport issue (output push, id, vs, vl, vstart, input busy);
  modport slot (input push, id, vs, vl, vstart, output busy);

endinterface

//--- req_intake.sv
/*
 * Request intake
 * Drops repeated broadcasts of one ID and buffers one request, falling through when empty
 */
`timescale 1ns/1ps

module req_intake (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          pe_req_valid_i,
  output logic                          pe_req_ready_o,
  input  logic [lane_seq_pkg::VidW-1:0] pe_req_id_i,
  input  logic [lane_seq_pkg::VfuW-1:0] pe_req_vfu_i,
  input  logic [lane_seq_pkg::VlW-1:0]  pe_req_vl_i,
  input  logic [lane_seq_pkg::VlW-1:0]  pe_req_vstart_i,
  input  logic [lane_seq_pkg::RegW-1:0] pe_req_vs1_i,
  input  logic [lane_seq_pkg::RegW-1:0] pe_req_vs2_i,
  input  logic [lane_seq_pkg::RegW-1:0] pe_req_vd_i,
  input  logic                          pe_req_vm_i,
  input  logic                          pe_req_use_vs1_i,
  input  logic                          pe_req_use_vs2_i,
  vinsn_req_if.intake                   req
);
  import lane_seq_pkg::*;

  logic [VidW-1:0] last_id_q;
  logic            mask_en_q;
  logic            valid_msk;
  logic            accept;

  logic            full_q;
  logic            load;
  logic [ReqW-1:0] word_in;
  logic [ReqW-1:0] word_q;
  logic [ReqW-1:0] word_out;

  //////////////////////////////
  // Duplicate mask
  //////////////////////////////

  // The main sequencer keeps broadcasting an ID until every lane took it,
  // so the same ID is ignored until valid drops
  assign valid_msk = pe_req_valid_i && !(mask_en_q && (pe_req_id_i == last_id_q));
  assign accept    = valid_msk && pe_req_ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      last_id_q <= '0;
      mask_en_q <= 1'b0;
    end else if (accept) begin
      last_id_q <= pe_req_id_i;
      mask_en_q <= 1'b1;
    end else if (!pe_req_valid_i) begin
      mask_en_q <= 1'b0;
    end
  end

  //////////////////////////////
  // Fall-through register
  //////////////////////////////

  assign pe_req_ready_o = !full_q || req.ready;

  assign word_in = {pe_req_id_i, pe_req_vfu_i, pe_req_vl_i, pe_req_vstart_i, pe_req_vs1_i,
                    pe_req_vs2_i, pe_req_vd_i, pe_req_vm_i, pe_req_use_vs1_i,
                    pe_req_use_vs2_i};
  assign word_out = full_q ? word_q : word_in;

  assign req.valid = full_q || valid_msk;
  assign {req.id, req.vfu, req.vl, req.vstart, req.vs1, req.vs2, req.vd, req.vm,
          req.use_vs1, req.use_vs2} = word_out;

  // Store the new request unless issue takes it on the way through
  assign load = accept && (full_q || !req.ready);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (req.ready) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      word_q <= word_in;
    end
  end

endmodule

//--- opreq_slots.sv
/*
 * Operand request slots
 * One command register per operand queue, held until the requester takes it
 */
`timescale 1ns/1ps

module opreq_slots (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  opreq_if.slot                                                   slots,
  input  logic [lane_seq_pkg::NrOpQueues-1:0]                     opreq_ready_i,
  output logic [lane_seq_pkg::NrOpQueues-1:0]                     opreq_valid_o,
  output logic [lane_seq_pkg::NrOpQueues-1:0][lane_seq_pkg::VidW-1:0] opreq_id_o,
  output logic [lane_seq_pkg::NrOpQueues-1:0][lane_seq_pkg::RegW-1:0] opreq_vs_o,
  output logic [lane_seq_pkg::NrOpQueues-1:0][lane_seq_pkg::VlW-1:0]  opreq_vl_o,
  output logic [lane_seq_pkg::NrOpQueues-1:0][lane_seq_pkg::VlW-1:0]  opreq_vstart_o
);
  import lane_seq_pkg::*;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      opreq_valid_o <= '0;
    end else begin
      // A push refills the slot even when the old command leaves this cycle
      opreq_valid_o <= slots.push | (opreq_valid_o & ~opreq_ready_i);
    end
  end

  always_ff @(posedge clk_i) begin
    for (int q = 0; q < NrOpQueues; q++) begin
      if (slots.push[q]) begin
        opreq_id_o[q]     <= slots.id[q];
        opreq_vs_o[q]     <= slots.vs[q];
        opreq_vl_o[q]     <= slots.vl[q];
        opreq_vstart_o[q] <= slots.vstart[q];
      end
    end
  end

  // Issue stalls on any occupied slot of its unit
  assign slots.busy = opreq_valid_o;

endmodule

//--- lane_issue.sv
/*
 * Lane issue stage
 * Splits vl and vstart for this lane, issues the unit operation and operand commands
 */
`timescale 1ns/1ps

module lane_issue (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic [lane_seq_pkg::LaneIdW-1:0]    lane_id_i,
  vinsn_req_if.issue                          req,
  opreq_if.issue                              oq,
  input  logic [lane_seq_pkg::NrVInsn-1:0]    pe_vinsn_running_i,
  input  logic [lane_seq_pkg::NrVInsn-1:0]    alu_done_i,
  input  logic [lane_seq_pkg::NrVInsn-1:0]    mfpu_done_i,
  output logic [lane_seq_pkg::NrVInsn-1:0]    pe_resp_vinsn_done_o,
  output logic                                vfu_op_valid_o,
  output logic [lane_seq_pkg::VidW-1:0]       vfu_op_id_o,
  output logic [lane_seq_pkg::VfuW-1:0]       vfu_op_vfu_o,
  output logic [lane_seq_pkg::VlW-1:0]        vfu_op_vl_o,
  output logic [lane_seq_pkg::VlW-1:0]        vfu_op_vstart_o,
  output logic [lane_seq_pkg::RegW-1:0]       vfu_op_vd_o,
  output logic                                vfu_op_vm_o,
  output logic                                alu_vinsn_done_o,
  output logic                                mfpu_vinsn_done_o
);
  import lane_seq_pkg::*;

  // Elements of a length-len vector that map to this lane
  function automatic logic [VlW-1:0] lane_share(logic [VlW-1:0] len,
                                                logic [LaneIdW-1:0] lane);
    return (len >> LaneIdW) + VlW'(lane < len[LaneIdW-1:0]);
  endfunction

  // len divided by 2**sh, rounded up
  function automatic logic [VlW-1:0] ceil_shift(logic [VlW-1:0] len, int sh);
    logic [VlW-1:0] rem_mask;
    rem_mask = (VlW'(1) << sh) - VlW'(1);
    return (len >> sh) + VlW'(|(len & rem_mask));
  endfunction

  logic [VlW-1:0]     lane_vl;
  logic [VlW-1:0]     lane_vstart;
  logic [VlW-1:0]     sta_vl;
  logic [VlW-1:0]     mask_vl;
  logic               unit_busy;
  logic               fire;
  logic               is_arith;
  logic               mute;
  logic               op_valid_d;
  logic [NrVInsn-1:0] id_vec;
  logic [NrVInsn-1:0] running_q;
  logic [NrVInsn-1:0] running_now;

  //////////////////////////////
  // Lane share
  //////////////////////////////

  assign lane_vl     = lane_share(req.vl, lane_id_i);
  assign lane_vstart = lane_share(req.vstart, lane_id_i);
  // Stores and mask words leave the lane, so every lane asks for the rounded-up count
  assign sta_vl      = ceil_shift(req.vl, LaneIdW);
  assign mask_vl     = ceil_shift(req.vl, $clog2(NrLanes * ElenBits));

  //////////////////////////////
  // Stall and issue
  //////////////////////////////

  always_comb begin
    case (req.vfu)
      VfuAlu:   unit_busy = oq.busy[OqAluA] || oq.busy[OqAluB] || oq.busy[OqMaskM];
      VfuMfpu:  unit_busy = oq.busy[OqMfpuA] || oq.busy[OqMfpuB] || oq.busy[OqMaskM];
      VfuStore: unit_busy = oq.busy[OqStA] || oq.busy[OqMaskM];
      default:  unit_busy = 1'b0;
    endcase
  end

  assign req.ready   = !(req.valid && unit_busy);
  assign running_now = running_q & pe_vinsn_running_i;
  // A request whose ID still runs is taken and dropped
  assign fire        = req.valid && req.ready && !running_now[req.id];
  assign is_arith    = (req.vfu == VfuAlu) || (req.vfu == VfuMfpu);
  // No elements in this lane, so the ALU or FPU has nothing to do
  assign mute        = fire && is_arith && (lane_vl == '0);
  assign op_valid_d  = fire && !mute;
  assign id_vec      = NrVInsn'(1) << req.id;

  //////////////////////////////
  // Operand commands
  //////////////////////////////

  always_comb begin
    for (int q = 0; q < NrOpQueues; q++) begin
      oq.id[q]     = req.id;
      oq.vs[q]     = req.vs1;
      oq.vl[q]     = lane_vl;
      oq.vstart[q] = lane_vstart;
    end
    oq.vs[OqAluB]  = req.vs2;
    oq.vs[OqMfpuB] = req.vs2;
    oq.vs[OqMaskM] = VmaskReg;
    oq.vl[OqStA]   = sta_vl;
    oq.vl[OqMaskM] = mask_vl;

    oq.push = '0;
    if (fire) begin
      case (req.vfu)
        VfuAlu: begin
          oq.push[OqAluA] = req.use_vs1;
          oq.push[OqAluB] = req.use_vs2;
        end
        VfuMfpu: begin
          oq.push[OqMfpuA] = req.use_vs1;
          oq.push[OqMfpuB] = req.use_vs2;
        end
        VfuStore: oq.push[OqStA] = req.use_vs1;
        default: ;
      endcase
      oq.push[OqMaskM] = !req.vm && (is_arith || (req.vfu == VfuStore));
    end
  end

  //////////////////////////////
  // Operation and tracking
  //////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q            <= '0;
      vfu_op_valid_o       <= 1'b0;
      pe_resp_vinsn_done_o <= '0;
      alu_vinsn_done_o     <= 1'b0;
      mfpu_vinsn_done_o    <= 1'b0;
    end else begin
      running_q            <= running_now | (op_valid_d ? id_vec : '0);
      vfu_op_valid_o       <= op_valid_d;
      // Muted work is reported done together with the units' completions
      pe_resp_vinsn_done_o <= alu_done_i | mfpu_done_i | (mute ? id_vec : '0);
      alu_vinsn_done_o     <= |alu_done_i;
      mfpu_vinsn_done_o    <= |mfpu_done_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fire) begin
      vfu_op_id_o     <= req.id;
      vfu_op_vfu_o    <= req.vfu;
      vfu_op_vl_o     <= lane_vl;
      vfu_op_vstart_o <= lane_vstart;
      vfu_op_vd_o     <= req.vd;
      vfu_op_vm_o     <= req.vm;
    end
  end

endmodule

//--- lane_sequencer.sv
/*
 * Lane sequencer
 * Request intake, issue stage and operand request slots of one lane
 */
`timescale 1ns/1ps

module lane_sequencer (
  input  logic                                                    clk_i,
  input  logic                                                    rst_ni,
  input  logic [lane_seq_pkg::LaneIdW-1:0]                        lane_id_i,
  // Broadcast from the main sequencer
  input  logic                                                    pe_req_valid_i,
  output logic                                                    pe_req_ready_o,
  input  logic [lane_seq_pkg::VidW-1:0]                           pe_req_id_i,
  input  logic [lane_seq_pkg::VfuW-1:0]                           pe_req_vfu_i,
  input  logic [lane_seq_pkg::VlW-1:0]                            pe_req_vl_i,
  input  logic [lane_seq_pkg::VlW-1:0]                            pe_req_vstart_i,
  input  logic [lane_seq_pkg::RegW-1:0]                           pe_req_vs1_i,
  input  logic [lane_seq_pkg::RegW-1:0]                           pe_req_vs2_i,
  input  logic [lane_seq_pkg::RegW-1:0]                           pe_req_vd_i,
  input  logic                                                    pe_req_vm_i,
  input  logic                                                    pe_req_use_vs1_i,
  input  logic                                                    pe_req_use_vs2_i,
  input  logic [lane_seq_pkg::NrVInsn-1:0]                        pe_vinsn_running_i,
  output logic [lane_seq_pkg::NrVInsn-1:0]                        pe_resp_vinsn_done_o,
  // Functional units
  output logic                                                    vfu_op_valid_o,
  output logic [lane_seq_pkg::VidW-1:0]                           vfu_op_id_o,
  output logic [lane_seq_pkg::VfuW-1:0]                           vfu_op_vfu_o,
  output logic [lane_seq_pkg::VlW-1:0]                            vfu_op_vl_o,
  output logic [lane_seq_pkg::VlW-1:0]                            vfu_op_vstart_o,
  output logic [lane_seq_pkg::RegW-1:0]                           vfu_op_vd_o,
  output logic                                                    vfu_op_vm_o,
  input  logic [lane_seq_pkg::NrVInsn-1:0]                        alu_done_i,
  input  logic [lane_seq_pkg::NrVInsn-1:0]                        mfpu_done_i,
  output logic                                                    alu_vinsn_done_o,
  output logic                                                    mfpu_vinsn_done_o,
  // Operand requester
  output logic [lane_seq_pkg::NrOpQueues-1:0]                     opreq_valid_o,
  input  logic [lane_seq_pkg::NrOpQueues-1:0]                     opreq_ready_i,
  output logic [lane_seq_pkg::NrOpQueues-1:0][lane_seq_pkg::VidW-1:0] opreq_id_o,
  output logic [lane_seq_pkg::NrOpQueues-1:0][lane_seq_pkg::RegW-1:0] opreq_vs_o,
  output logic [lane_seq_pkg::NrOpQueues-1:0][lane_seq_pkg::VlW-1:0]  opreq_vl_o,
  output logic [lane_seq_pkg::NrOpQueues-1:0][lane_seq_pkg::VlW-1:0]  opreq_vstart_o
);

  vinsn_req_if u_req_if ();
  opreq_if     u_oq_if ();

  req_intake u_intake (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .pe_req_valid_i   (pe_req_valid_i),
    .pe_req_ready_o   (pe_req_ready_o),
    .pe_req_id_i      (pe_req_id_i),
    .pe_req_vfu_i     (pe_req_vfu_i),
    .pe_req_vl_i      (pe_req_vl_i),
    .pe_req_vstart_i  (pe_req_vstart_i),
    .pe_req_vs1_i     (pe_req_vs1_i),
    .pe_req_vs2_i     (pe_req_vs2_i),
    .pe_req_vd_i      (pe_req_vd_i),
    .pe_req_vm_i      (pe_req_vm_i),
    .pe_req_use_vs1_i (pe_req_use_vs1_i),
    .pe_req_use_vs2_i (pe_req_use_vs2_i),
    .req              (u_req_if.intake)
  );

  lane_issue u_issue (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .lane_id_i            (lane_id_i),
    .req                  (u_req_if.issue),
    .oq                   (u_oq_if.issue),
    .pe_vinsn_running_i   (pe_vinsn_running_i),
    .alu_done_i           (alu_done_i),
    .mfpu_done_i          (mfpu_done_i),
    .pe_resp_vinsn_done_o (pe_resp_vinsn_done_o),
    .vfu_op_valid_o       (vfu_op_valid_o),
    .vfu_op_id_o          (vfu_op_id_o),
    .vfu_op_vfu_o         (vfu_op_vfu_o),
    .vfu_op_vl_o          (vfu_op_vl_o),
    .vfu_op_vstart_o      (vfu_op_vstart_o),
    .vfu_op_vd_o          (vfu_op_vd_o),
    .vfu_op_vm_o          (vfu_op_vm_o),
    .alu_vinsn_done_o     (alu_vinsn_done_o),
    .mfpu_vinsn_done_o    (mfpu_vinsn_done_o)
  );

  opreq_slots u_slots (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slots          (u_oq_if.slot),
    .opreq_ready_i  (opreq_ready_i),
    .opreq_valid_o  (opreq_valid_o),
    .opreq_id_o     (opreq_id_o),
    .opreq_vs_o     (opreq_vs_o),
    .opreq_vl_o     (opreq_vl_o),
    .opreq_vstart_o (opreq_vstart_o)
  );

endmodule

//--- lane_sequencer_sva.sv
/*
 * Operand slot assertions
 * Held commands stay stable until taken, and slots leave reset empty
 */
`timescale 1ns/1ps

module lane_sequencer_sva (
  input logic                                                    clk_i,
  input logic                                                    rst_ni,
  input logic [lane_seq_pkg::NrOpQueues-1:0]                     opreq_ready_i,
  input logic [lane_seq_pkg::NrOpQueues-1:0]                     opreq_valid_o,
  input logic [lane_seq_pkg::NrOpQueues-1:0][lane_seq_pkg::VidW-1:0] opreq_id_o,
  input logic [lane_seq_pkg::NrOpQueues-1:0][lane_seq_pkg::RegW-1:0] opreq_vs_o,
  input logic [lane_seq_pkg::NrOpQueues-1:0][lane_seq_pkg::VlW-1:0]  opreq_vl_o,
  input logic [lane_seq_pkg::NrOpQueues-1:0][lane_seq_pkg::VlW-1:0]  opreq_vstart_o
);
  import lane_seq_pkg::*;

  // First clock with reset released still sees every slot empty
  assert property (@(posedge clk_i) $rose(rst_ni) |-> opreq_valid_o == '0)
    else $error("Operand slot valid in the cycle after reset");

  for (genvar q = 0; q < NrOpQueues; q++) begin : g_slot
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        opreq_valid_o[q] && !opreq_ready_i[q] |=>
        opreq_valid_o[q] && $stable(opreq_id_o[q]) && $stable(opreq_vs_o[q]) &&
        $stable(opreq_vl_o[q]) && $stable(opreq_vstart_o[q]))
      else $error("Operand slot %0d changed before it was taken", q);
  end

endmodule

bind opreq_slots lane_sequencer_sva u_sva (.*);

//--- lane_sequencer_tb.sv
/*
 * Lane sequencer testbench
 * Random broadcasts from a fixed seed, checked against queues of expected ops and commands
 */
`timescale 1ns/1ps

module lane_sequencer_tb;
  import lane_seq_pkg::*;

  localparam logic [LaneIdW-1:0] LaneId  = 1;
  localparam int                 MaxWait = 200;
  localparam int                 OpW     = VidW + VfuW + 2 * VlW + RegW + 1;
  localparam int                 CmdW    = VidW + RegW + 2 * VlW;

  logic clk_i;
  logic rst_ni;
  logic [LaneIdW-1:0] lane_id_i;
  logic pe_req_valid_i;
  logic pe_req_ready_o;
  logic [VidW-1:0] pe_req_id_i;
  logic [VfuW-1:0] pe_req_vfu_i;
  logic [VlW-1:0] pe_req_vl_i;
  logic [VlW-1:0] pe_req_vstart_i;
  logic [RegW-1:0] pe_req_vs1_i;
  logic [RegW-1:0] pe_req_vs2_i;
  logic [RegW-1:0] pe_req_vd_i;
  logic pe_req_vm_i;
  logic pe_req_use_vs1_i;
  logic pe_req_use_vs2_i;
  logic [NrVInsn-1:0] pe_vinsn_running_i;
  logic [NrVInsn-1:0] pe_resp_vinsn_done_o;
  logic vfu_op_valid_o;
  logic [VidW-1:0] vfu_op_id_o;
  logic [VfuW-1:0] vfu_op_vfu_o;
  logic [VlW-1:0] vfu_op_vl_o;
  logic [VlW-1:0] vfu_op_vstart_o;
  logic [RegW-1:0] vfu_op_vd_o;
  logic vfu_op_vm_o;
  logic [NrVInsn-1:0] alu_done_i;
  logic [NrVInsn-1:0] mfpu_done_i;
  logic alu_vinsn_done_o;
  logic mfpu_vinsn_done_o;
  logic [NrOpQueues-1:0] opreq_valid_o;
  logic [NrOpQueues-1:0] opreq_ready_i;
  logic [NrOpQueues-1:0][VidW-1:0] opreq_id_o;
  logic [NrOpQueues-1:0][RegW-1:0] opreq_vs_o;
  logic [NrOpQueues-1:0][VlW-1:0] opreq_vl_o;
  logic [NrOpQueues-1:0][VlW-1:0] opreq_vstart_o;

  // Reference model state
  logic [31:0] rng;
  int n_checks;
  int n_errors;
  logic [OpW-1:0] op_q[$];
  logic [CmdW-1:0] cmd_q[NrOpQueues][$];
  logic [VidW-1:0] run_hist[$];
  logic [NrVInsn-1:0] run_bits;
  logic [NrVInsn-1:0] pending_mute;
  logic [VidW-1:0] next_id;
  logic req_taken;
  logic hold_ready;
  logic nxt_valid;
  logic [ReqW-1:0] nxt_req;
  logic [NrVInsn-1:0] prev_alu_done;
  logic [NrVInsn-1:0] prev_mfpu_done;
  logic [NrOpQueues-1:0] prev_valid;
  logic [NrOpQueues-1:0] prev_ready;
  logic [CmdW-1:0] prev_cmd[NrOpQueues];

  lane_sequencer u_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Elements of a length that fall to this lane
  function automatic int share(input int len);
    return len / NrLanes + ((int'(LaneId) < len % NrLanes) ? 1 : 0);
  endfunction

  function automatic logic [CmdW-1:0] cmd_word(input logic [VidW-1:0] id,
                                               input logic [RegW-1:0] vs,
                                               input int len, input int start);
    return {id, vs, VlW'(len), VlW'(start)};
  endfunction

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    n_errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0t while waiting for %s", $time, what);
    $display("Checks: %0d, errors: %0d", n_checks, n_errors + 1);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  //////////////////////////////
  // Model update on acceptance
  //////////////////////////////

  task automatic accept_request();
    int vl;
    int lv;
    int ls;
    vl = pe_req_vl_i;
    lv = share(vl);
    ls = share(pe_req_vstart_i);
    req_taken = 1'b1;
    run_hist.push_back(pe_req_id_i);
    if (run_hist.size() > 3)
      void'(run_hist.pop_front());
    run_bits = '0;
    foreach (run_hist[i])
      run_bits[run_hist[i]] = 1'b1;
    // Arithmetic work with no elements here is muted and reported done at once
    if ((pe_req_vfu_i == VfuAlu || pe_req_vfu_i == VfuMfpu) && lv == 0) begin
      pending_mute[pe_req_id_i] = 1'b1;
    end else begin
      op_q.push_back({pe_req_id_i, pe_req_vfu_i, VlW'(lv), VlW'(ls), pe_req_vd_i, pe_req_vm_i});
    end
    case (pe_req_vfu_i)
      VfuAlu: begin
        if (pe_req_use_vs1_i)
          cmd_q[OqAluA].push_back(cmd_word(pe_req_id_i, pe_req_vs1_i, lv, ls));
        if (pe_req_use_vs2_i)
          cmd_q[OqAluB].push_back(cmd_word(pe_req_id_i, pe_req_vs2_i, lv, ls));
      end
      VfuMfpu: begin
        if (pe_req_use_vs1_i)
          cmd_q[OqMfpuA].push_back(cmd_word(pe_req_id_i, pe_req_vs1_i, lv, ls));
        if (pe_req_use_vs2_i)
          cmd_q[OqMfpuB].push_back(cmd_word(pe_req_id_i, pe_req_vs2_i, lv, ls));
      end
      default: begin
        if (pe_req_use_vs1_i)
          cmd_q[OqStA].push_back(cmd_word(pe_req_id_i, pe_req_vs1_i,
                                          (vl + NrLanes - 1) / NrLanes, ls));
      end
    endcase
    if (!pe_req_vm_i)
      cmd_q[OqMaskM].push_back(cmd_word(pe_req_id_i, VmaskReg,
                                        (vl + NrLanes * ElenBits - 1) / (NrLanes * ElenBits),
                                        ls));
  endtask

  //////////////////////////////
  // Per-cycle monitor
  //////////////////////////////

  task automatic monitor();
    int q;
    logic [CmdW-1:0] now_cmd;
    logic [NrVInsn-1:0] base;
    logic [NrVInsn-1:0] extra;
    if (vfu_op_valid_o) begin
      if (op_q.size() == 0) begin
        report_error("unit operation issued while none was expected");
      end else begin
        check_eq({vfu_op_id_o, vfu_op_vfu_o, vfu_op_vl_o, vfu_op_vstart_o, vfu_op_vd_o,
                  vfu_op_vm_o}, op_q.pop_front(), "unit op {id,vfu,vl,vstart,vd,vm}");
      end
    end
    for (q = 0; q < NrOpQueues; q++) begin
      now_cmd = {opreq_id_o[q], opreq_vs_o[q], opreq_vl_o[q], opreq_vstart_o[q]};
      if (prev_valid[q] && !prev_ready[q]) begin
        check_eq(opreq_valid_o[q], 1'b1, $sformatf("slot %0d valid held", q));
        check_eq(now_cmd, prev_cmd[q], $sformatf("slot %0d command held", q));
      end
      if (opreq_valid_o[q] && opreq_ready_i[q]) begin
        if (cmd_q[q].size() == 0)
          report_error($sformatf("slot %0d handed over a command nobody issued", q));
        else
          check_eq(now_cmd, cmd_q[q].pop_front(), $sformatf("slot %0d {id,vs,vl,vstart}", q));
      end
      prev_valid[q] = opreq_valid_o[q];
      prev_ready[q] = opreq_ready_i[q];
      prev_cmd[q]   = now_cmd;
    end
    check_eq(alu_vinsn_done_o, |prev_alu_done, "alu done");
    check_eq(mfpu_vinsn_done_o, |prev_mfpu_done, "mfpu done");
    base  = prev_alu_done | prev_mfpu_done;
    extra = pe_resp_vinsn_done_o & ~base;
    check_eq(pe_resp_vinsn_done_o & base, base, "reported done bits");
    check_eq(extra & ~pending_mute, '0, "done bits with no cause");
    pending_mute = pending_mute & ~extra;
    if (pe_req_valid_i && pe_req_ready_o && !req_taken)
      accept_request();
  endtask

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic step();
    logic [31:0] r;
    @(negedge clk_i);
    r = next_rand();
    prev_alu_done  = alu_done_i;
    prev_mfpu_done = mfpu_done_i;
    pe_req_valid_i = nxt_valid;
    {pe_req_id_i, pe_req_vfu_i, pe_req_vl_i, pe_req_vstart_i, pe_req_vs1_i, pe_req_vs2_i,
     pe_req_vd_i, pe_req_vm_i, pe_req_use_vs1_i, pe_req_use_vs2_i} = nxt_req;
    pe_vinsn_running_i = run_bits;
    opreq_ready_i      = hold_ready ? '0 : r[5:0];
    alu_done_i         = '0;
    mfpu_done_i        = '0;
    // Units only finish work that runs and is not muted
    if (r[9:7] == 3'd0)
      alu_done_i = (NrVInsn'(1) << r[12:10]) & run_bits & ~pending_mute;
    if (r[15:13] == 3'd0)
      mfpu_done_i = (NrVInsn'(1) << r[18:16]) & run_bits & ~pending_mute;
    #2;
    monitor();
  endtask

  task automatic start_request(input logic [VfuW-1:0] vfu, input logic [VlW-1:0] vl,
                               input logic [VlW-1:0] vstart, input logic vm,
                               input logic use1, input logic use2);
    logic [31:0] r;
    r         = next_rand();
    nxt_req   = {next_id, vfu, vl, vstart, r[4:0], r[9:5], r[14:10], vm, use1, use2};
    nxt_valid = 1'b1;
    req_taken = 1'b0;
    next_id   = next_id + 1'b1;
  endtask

  task automatic wait_accept();
    int n;
    n = 0;
    step();
    while (!req_taken) begin
      n++;
      if (n > MaxWait)
        stop_on_timeout("request acceptance");
      step();
    end
  endtask

  // Keep broadcasting the same ID for a while, then drop valid
  task automatic release_request(input int extra);
    repeat (extra) step();
    nxt_valid = 1'b0;
    step();
  endtask

  task automatic send_request(input logic [VfuW-1:0] vfu, input logic [VlW-1:0] vl,
                              input logic [VlW-1:0] vstart, input logic vm,
                              input logic use1, input logic use2, input int extra);
    start_request(vfu, vl, vstart, vm, use1, use2);
    wait_accept();
    release_request(extra);
  endtask

  task automatic drain();
    int n;
    int busy;
    n    = 0;
    busy = 1;
    while (busy != 0) begin
      busy = op_q.size() + int'(pending_mute != '0) + int'(opreq_valid_o != '0);
      foreach (cmd_q[q])
        busy += cmd_q[q].size();
      if (busy != 0) begin
        n++;
        if (n > MaxWait)
          stop_on_timeout("outstanding work to drain");
        step();
      end
    end
  endtask

  task automatic mute_case(input logic [VfuW-1:0] vfu, input logic [VlW-1:0] vl,
                           input logic vm);
    logic [VidW-1:0] id;
    drain();
    id = next_id;
    start_request(vfu, vl, 16'd5, vm, 1'b1, 1'b1);
    wait_accept();
    step();
    check_eq(pe_resp_vinsn_done_o[id], 1'b1, "done bit one cycle after muted issue");
    check_eq(vfu_op_valid_o, 1'b0, "no unit operation for muted work");
    release_request(0);
  endtask

  initial begin
    logic [31:0] r;
    logic [VfuW-1:0] vfu;
    logic [VlW-1:0] vl;
    rng = 32'd17;
    n_checks = 0;
    n_errors = 0;
    rst_ni = 1'b0;
    lane_id_i = LaneId;
    pe_req_valid_i = 1'b0;
    {pe_req_id_i, pe_req_vfu_i, pe_req_vl_i, pe_req_vstart_i, pe_req_vs1_i, pe_req_vs2_i,
     pe_req_vd_i, pe_req_vm_i, pe_req_use_vs1_i, pe_req_use_vs2_i} = '0;
    pe_vinsn_running_i = '0;
    alu_done_i = '0;
    mfpu_done_i = '0;
    opreq_ready_i = '0;
    nxt_valid = 1'b0;
    nxt_req = '0;
    run_bits = '0;
    pending_mute = '0;
    next_id = '0;
    req_taken = 1'b1;
    hold_ready = 1'b0;
    prev_alu_done = '0;
    prev_mfpu_done = '0;
    prev_valid = '0;
    prev_ready = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    // Reset leaves no slot, operation or completion pending
    check_eq(opreq_valid_o, '0, "slot valids after reset");
    check_eq(vfu_op_valid_o, 1'b0, "unit op valid after reset");
    check_eq(pe_resp_vinsn_done_o, '0, "done bits after reset");
    check_eq({alu_vinsn_done_o, mfpu_vinsn_done_o}, '0, "unit done flags after reset");

    // Random mix, each broadcast held for a few extra cycles
    repeat (60) begin
      r   = next_rand();
      vfu = (r[1:0] == 2'd3) ? VfuAlu : r[1:0];
      vl  = (r[4:2] == 3'd0) ? VlW'(r[7:5]) : VlW'(r[17:8]);
      send_request(vfu, vl, VlW'(r[25:18]), r[26], r[27], r[28], int'(r[30:29]));
    end

    // Back-pressure with the operand requester stalled
    drain();
    hold_ready = 1'b1;
    send_request(VfuAlu, 16'd64, 16'd8, 1'b1, 1'b1, 1'b0, 0);
    send_request(VfuAlu, 16'd64, 16'd8, 1'b1, 1'b1, 1'b0, 0);
    start_request(VfuAlu, 16'd64, 16'd8, 1'b1, 1'b1, 1'b0);
    repeat (6) begin
      step();
      check_eq(pe_req_ready_o, 1'b0, "ready while the ALU slot is busy");
    end
    hold_ready = 1'b0;
    wait_accept();
    release_request(0);

    mute_case(VfuAlu, 16'd1, 1'b0);
    mute_case(VfuMfpu, 16'd0, 1'b1);
    drain();

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- vlog.f
lane_seq_pkg.sv
lane_seq_if.sv
req_intake.sv
opreq_slots.sv
lane_issue.sv
lane_sequencer.sv
lane_sequencer_sva.sv
lane_sequencer_tb.sv

//--- Bender.yml
package:
  name: lane_sequencer

sources:
  - lane_seq_pkg.sv
  - lane_seq_if.sv
  - req_intake.sv
  - opreq_slots.sv
  - lane_issue.sv
  - lane_sequencer.sv
  - target: test
    files:
      - lane_sequencer_sva.sv
      - lane_sequencer_tb.sv
